/* hdl/reward_pkg.sv */
/*
 * Shared definitions for the power-up subsystem of the tank game.
 * Holds the reward kinds, the grid coordinate type, the pickup record,
 * the cheat switch bundle and the status flag struct.
 * Every module of the subsystem imports this package, so it is compiled first.
 */
package reward_pkg;

	// the playfield is a 32 by 32 tile grid
	localparam int GRID_BITS = 5;

	typedef logic [GRID_BITS-1:0] grid_coord_t;

	// pickup kinds as the spawner draws them, none marks an empty slot
	typedef enum logic [2:0]
	{
		KIND_NONE   = 3'd0,
		KIND_SHIELD = 3'd1,
		KIND_SPEED  = 3'd2,
		KIND_FREEZE = 3'd3,
		KIND_LASER  = 3'd4
	} reward_kind_e;

	// one duration timer per timed reward
	localparam int NUM_TIMED = 4;
	localparam int SLOT_W    = $clog2(NUM_TIMED);

	typedef logic [SLOT_W-1:0] slot_idx_t;

	// fixed meaning of each timer slot
	localparam slot_idx_t SLOT_INVINCIBLE = 2'd0;
	localparam slot_idx_t SLOT_FASTER     = 2'd1;
	localparam slot_idx_t SLOT_FROZEN     = 2'd2;
	localparam slot_idx_t SLOT_LASER      = 2'd3;

	// the pickup currently on the map, also exported for the display block
	typedef struct packed
	{
		logic         valid;
		reward_kind_e kind;
		grid_coord_t  xpos;
		grid_coord_t  ypos;
	} pickup_t;

	typedef struct packed
	{
		grid_coord_t xpos;
		grid_coord_t ypos;
	} tank_pos_t;

	// active rewards as the game logic consumes them
	typedef struct packed
	{
		logic invincible;
		logic addtime;
		logic faster;
		logic frozen;
		logic laser;
	} reward_flags_t;

	// debug switches plus the start-of-round protection request
	typedef struct packed
	{
		logic shield;
		logic speed;
		logic freeze;
		logic laser;
		logic protect;
	} cheat_t;

endpackage

/* hdl/pickup_spawner.sv */
/*
 * Places one pickup at a time on the tile grid.
 * A free-running LFSR supplies the kind and the coordinates. Once the
 * dispatcher reports a collection the pickup disappears and a new one is
 * drawn after RESPAWN_DELAY ticks. The same delay applies after reset.
 */
`timescale 1ns/1ps

module pickup_spawner
#(
	parameter int RESPAWN_DELAY = 8
)
(
	input  logic               clk_4Hz,
	input  logic               reset,
	input  logic               enable,
	input  logic               collect,
	output reward_pkg::pickup_t pickup
);

	import reward_pkg::*;

	// the countdown only has to hold RESPAWN_DELAY-1
	localparam int DLY_W = (RESPAWN_DELAY > 1) ? $clog2(RESPAWN_DELAY) : 1;

	localparam logic [15:0] LFSR_SEED = 16'hACE1;

	logic [15:0]      lfsr;
	logic             feedback;
	logic [DLY_W-1:0] delay_cnt;
	logic [2:0]       kind_raw;

	// fibonacci taps 16, 14, 13, 11
	assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	// two random bits give 0..3 and are shifted up so a drawn kind is never none
	assign kind_raw = {1'b0, lfsr[1:0]} + 3'd1;

	always_ff @(posedge clk_4Hz)
	begin
		if (reset)
		begin
			lfsr <= LFSR_SEED;
		end
		else if (enable)
		begin
			lfsr <= {lfsr[14:0], feedback};
		end
	end

	always_ff @(posedge clk_4Hz)
	begin
		if (reset)
		begin
			pickup    <= '0;
			delay_cnt <= DLY_W'(RESPAWN_DELAY - 1);
		end
		else if (enable)
		begin
			if (pickup.valid)
			begin
				if (collect)
				begin
					// the pickup was taken so the respawn wait starts
					pickup.valid <= 1'b0;
					delay_cnt    <= DLY_W'(RESPAWN_DELAY - 1);
				end
			end
			else if (delay_cnt == '0)
			begin
				// the new tile may coincide with the tank position
				pickup.valid <= 1'b1;
				pickup.kind  <= reward_kind_e'(kind_raw);
				pickup.xpos  <= grid_coord_t'(lfsr[6:2]);
				pickup.ypos  <= grid_coord_t'(lfsr[11:7]);
			end
			else
			begin
				delay_cnt <= delay_cnt - 1'b1;
			end
		end
	end

	a_kind_known: assert property (
		@(posedge clk_4Hz) disable iff (reset)
		pickup.valid |-> pickup.kind != KIND_NONE
	)
	else $error("pickup shown with kind none");

endmodule

/* hdl/reward_dispatch.sv */
/*
 * Decides which reward is granted on each game tick.
 * Held cheat switches win over the pickup. Otherwise a tank standing on
 * the pickup collects it and the kind is mapped under the game mode.
 * All outputs are registered single-tick pulses.
 */
`timescale 1ns/1ps

module reward_dispatch
(
	input  logic                              clk_4Hz,
	input  logic                              reset,
	input  logic                              enable,
	input  logic                              mode_classic,
	input  logic                              mode_infinity,
	input  reward_pkg::tank_pos_t             tank,
	input  reward_pkg::cheat_t                cheat,
	input  reward_pkg::pickup_t               pickup,
	output logic [reward_pkg::NUM_TIMED-1:0] grant,
	output logic                              collect,
	output logic                              addtime_pulse
);

	import reward_pkg::*;

	logic                 cheat_held;
	logic                 on_tile;
	logic [NUM_TIMED-1:0] grant_next;
	logic                 collect_next;
	logic                 addtime_next;

	assign cheat_held = |cheat;

	// while collect is high the spawner has not cleared the pickup yet,
	// so the same pickup must not be taken twice
	assign on_tile = pickup.valid && !collect
		&& pickup.xpos == tank.xpos && pickup.ypos == tank.ypos;

	always_comb
	begin
		grant_next   = '0;
		collect_next = 1'b0;
		addtime_next = 1'b0;
		if (cheat_held)
		begin
			if (cheat.shield || cheat.protect)
				grant_next[SLOT_INVINCIBLE] = 1'b1;
			else if (cheat.speed)
				grant_next[SLOT_FASTER] = 1'b1;
			else if (cheat.freeze)
				grant_next[SLOT_FROZEN] = 1'b1;
			else if (cheat.laser)
				grant_next[SLOT_LASER] = 1'b1;
		end
		else if (on_tile)
		begin
			collect_next = 1'b1;
			case (pickup.kind)
				KIND_SHIELD:
				begin
					// classic mode protects, infinity mode buys extra time
					if (mode_classic)
						grant_next[SLOT_INVINCIBLE] = 1'b1;
					else if (mode_infinity)
						addtime_next = 1'b1;
				end
				KIND_SPEED:  grant_next[SLOT_FASTER] = 1'b1;
				KIND_FREEZE: grant_next[SLOT_FROZEN] = 1'b1;
				KIND_LASER:  grant_next[SLOT_LASER]  = 1'b1;
				default:     grant_next = '0;
			endcase
		end
	end

	always_ff @(posedge clk_4Hz)
	begin
		if (reset)
		begin
			grant         <= '0;
			collect       <= 1'b0;
			addtime_pulse <= 1'b0;
		end
		else if (enable)
		begin
			grant         <= grant_next;
			collect       <= collect_next;
			addtime_pulse <= addtime_next;
		end
	end

	a_grant_onehot: assert property (
		@(posedge clk_4Hz) disable iff (reset)
		$onehot0(grant)
	)
	else $error("more than one reward granted at once");

	a_cheat_blocks_collect: assert property (
		@(posedge clk_4Hz) disable iff (reset)
		$rose(collect) |-> !(|$past(cheat))
	)
	else $error("pickup collected while a cheat was held");

endmodule

/* hdl/reward_timer.sv */
/*
 * Hold counter for one timed reward.
 * A grant pulse loads DURATION ticks and raises active; the count then
 * runs down once per enabled tick and active drops with the last tick.
 * A grant that arrives while running simply reloads the count.
 */
`timescale 1ns/1ps

module reward_timer
#(
	parameter int DURATION = 30,
	parameter int CNT_W    = 6
)
(
	input  logic             clk_4Hz,
	input  logic             reset,
	input  logic             enable,
	input  logic             grant,
	output logic             active,
	output logic [CNT_W-1:0] remaining
);

	// the counter has to be able to hold the full duration
	if (DURATION < 1 || DURATION >= (1 << CNT_W))
	begin : g_bad_width
		$error("DURATION does not fit into CNT_W bits");
	end

	always_ff @(posedge clk_4Hz)
	begin
		if (reset)
		begin
			active    <= 1'b0;
			remaining <= '0;
		end
		else if (enable)
		begin
			if (grant)
			begin
				active    <= 1'b1;
				remaining <= CNT_W'(DURATION);
			end
			else if (active)
			begin
				if (remaining == CNT_W'(1))
				begin
					// last tick of the reward
					active    <= 1'b0;
					remaining <= '0;
				end
				else
				begin
					remaining <= remaining - 1'b1;
				end
			end
		end
	end

	a_count_consistent: assert property (
		@(posedge clk_4Hz) disable iff (reset)
		remaining <= CNT_W'(DURATION) && ((remaining == '0) == !active)
	)
	else $error("timer count out of range or out of step with active");

endmodule

/* hdl/reward_status.sv */
/*
 * Collects the timer array into the status seen by the rest of the game.
 * Flags follow the timers directly, last_remaining shows the count of the
 * most recently granted slot for the info panel, and collected_count
 * counts taken pickups up to 255.
 */
`timescale 1ns/1ps

module reward_status
#(
	parameter int DURATION = 30,
	parameter int CNT_W    = 6
)
(
	input  logic                              clk_4Hz,
	input  logic                              reset,
	input  logic                              enable,
	input  logic                              collect,
	input  logic                              addtime_pulse,
	input  logic [reward_pkg::NUM_TIMED-1:0] grant,
	input  logic [reward_pkg::NUM_TIMED-1:0] active,
	input  logic [CNT_W-1:0]                 remaining [reward_pkg::NUM_TIMED],
	output reward_pkg::reward_flags_t        flags,
	output logic [CNT_W-1:0]                 last_remaining,
	output logic [7:0]                        collected_count
);

	import reward_pkg::*;

	slot_idx_t last_slot;
	slot_idx_t grant_slot;

	always_comb
	begin
		flags.invincible = active[SLOT_INVINCIBLE];
		flags.addtime    = addtime_pulse;
		flags.faster     = active[SLOT_FASTER];
		flags.frozen     = active[SLOT_FROZEN];
		flags.laser      = active[SLOT_LASER];
	end

	// grant is one-hot, so this is a plain encoder
	always_comb
	begin
		grant_slot = '0;
		for (int i = 0; i < NUM_TIMED; i++)
		begin
			if (grant[i])
				grant_slot = slot_idx_t'(i);
		end
	end

	always_ff @(posedge clk_4Hz)
	begin
		if (reset)
		begin
			last_slot       <= '0;
			collected_count <= '0;
		end
		else if (enable)
		begin
			if (|grant)
				last_slot <= grant_slot;
			if (collect && collected_count != 8'hFF)
				collected_count <= collected_count + 1'b1;
		end
	end

	assign last_remaining = remaining[last_slot];

	// the panel shows a full count right after any grant
	a_panel_reload: assert property (
		@(posedge clk_4Hz) disable iff (reset)
		(enable && |grant) |=> last_remaining == CNT_W'(DURATION)
	)
	else $error("info panel count not reloaded after a grant");

endmodule

/* hdl/reward_top.sv */
/*
 * Top level of the power-up subsystem.
 * Wires the pickup spawner, the reward dispatcher, one duration timer per
 * timed reward and the status block. Durations and the respawn delay are
 * set here and handed down.
 */
`timescale 1ns/1ps

module reward_top
#(
	parameter int DURATION      = 30,
	parameter int RESPAWN_DELAY = 8,
	parameter int CNT_W         = 6
)
(
	input  logic                      clk_4Hz,
	input  logic                      reset,
	input  logic                      enable,
	input  logic                      mode_classic,
	input  logic                      mode_infinity,
	input  reward_pkg::tank_pos_t     tank,
	input  reward_pkg::cheat_t        cheat,
	output reward_pkg::pickup_t       pickup,
	output reward_pkg::reward_flags_t flags,
	output logic [CNT_W-1:0]          last_remaining,
	output logic [7:0]                collected_count
);

	import reward_pkg::*;

	logic                 collect;
	logic                 addtime_pulse;
	logic [NUM_TIMED-1:0] grant;
	logic [NUM_TIMED-1:0] active;
	logic [CNT_W-1:0]     remaining [NUM_TIMED];

	pickup_spawner #(.RESPAWN_DELAY(RESPAWN_DELAY)) u_spawner
	(
		.clk_4Hz (clk_4Hz),
		.reset   (reset),
		.enable  (enable),
		.collect (collect),
		.pickup  (pickup)
	);

	reward_dispatch u_dispatch
	(
		.clk_4Hz       (clk_4Hz),
		.reset         (reset),
		.enable        (enable),
		.mode_classic  (mode_classic),
		.mode_infinity (mode_infinity),
		.tank          (tank),
		.cheat         (cheat),
		.pickup        (pickup),
		.grant         (grant),
		.collect       (collect),
		.addtime_pulse (addtime_pulse)
	);

	// slot order follows the SLOT_ constants of the package
	for (genvar i = 0; i < NUM_TIMED; i++)
	begin : g_timer
		reward_timer #(.DURATION(DURATION), .CNT_W(CNT_W)) u_timer
		(
			.clk_4Hz   (clk_4Hz),
			.reset     (reset),
			.enable    (enable),
			.grant     (grant[i]),
			.active    (active[i]),
			.remaining (remaining[i])
		);
	end

	reward_status #(.DURATION(DURATION), .CNT_W(CNT_W)) u_status
	(
		.clk_4Hz         (clk_4Hz),
		.reset           (reset),
		.enable          (enable),
		.collect         (collect),
		.addtime_pulse   (addtime_pulse),
		.grant           (grant),
		.active          (active),
		.remaining       (remaining),
		.flags           (flags),
		.last_remaining  (last_remaining),
		.collected_count (collected_count)
	);

endmodule

/* tb/tb_reward.sv */
/*
 * Self-checking testbench for the power-up subsystem.
 * Runs directed phases for reset, collection, cheats, timer restart and
 * enable gating, then a long random phase. A cycle model of the grant,
 * timer, status and respawn rules is compared with every output on each
 * falling clock edge, while stimulus changes on the rising edge.
 */
`timescale 1ns/1ps

module tb_reward;

	import reward_pkg::*;

	localparam int DURATION       = 30;
	localparam int RESPAWN_DELAY  = 8;
	localparam int CNT_W          = 6;
	localparam int RANDOM_TICKS   = 3000;
	localparam int COLLECT_ROUNDS = 10;
	localparam int PICKUP_WAIT    = RESPAWN_DELAY + 8;

	// upper bound in ticks of all phases added up
	localparam int PLAN_TICKS = 16 + PICKUP_WAIT + 2
		+ 2 * COLLECT_ROUNDS * (PICKUP_WAIT + 10) + DURATION + 6
		+ DURATION + PICKUP_WAIT + 16
		+ 3 * DURATION + 24
		+ PICKUP_WAIT + 30
		+ RANDOM_TICKS;

	logic             clk_4Hz;
	logic             reset;
	logic             enable;
	logic             mode_classic;
	logic             mode_infinity;
	tank_pos_t        tank;
	cheat_t           cheat;
	pickup_t          pickup;
	reward_flags_t    flags;
	logic [CNT_W-1:0] last_remaining;
	logic [7:0]       collected_count;

	// reference model state
	logic [NUM_TIMED-1:0] m_grant;
	logic                 m_collect;
	logic                 m_addtime;
	int                   m_rem [NUM_TIMED];
	int                   m_last;
	int                   m_count;
	logic                 m_valid;
	int                   m_delay;

	pickup_t obs_pickup;
	pickup_t prev_pickup;
	int      errors;
	int      tests_run;
	int      tests_failed;
	int      test_start_errors;

	reward_top
	#(
		.DURATION      (DURATION),
		.RESPAWN_DELAY (RESPAWN_DELAY),
		.CNT_W         (CNT_W)
	) dut
	(
		.clk_4Hz         (clk_4Hz),
		.reset           (reset),
		.enable          (enable),
		.mode_classic    (mode_classic),
		.mode_infinity   (mode_infinity),
		.tank            (tank),
		.cheat           (cheat),
		.pickup          (pickup),
		.flags           (flags),
		.last_remaining  (last_remaining),
		.collected_count (collected_count)
	);

	initial clk_4Hz = 1'b0;
	always #20 clk_4Hz = ~clk_4Hz;

	task automatic compare_hex(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond === 1'b1)
		else
		begin
			$display("check failed at %0t: %s", $time, what);
			errors++;
		end
	endtask

	// the model steps with the DUT from the inputs seen at the same edge
	always @(posedge clk_4Hz)
	begin : model_step
		logic [NUM_TIMED-1:0] g;
		logic                 c;
		logic                 a;
		logic                 on_tile;
		if (reset)
		begin
			m_grant   = '0;
			m_collect = 1'b0;
			m_addtime = 1'b0;
			for (int i = 0; i < NUM_TIMED; i++)
				m_rem[i] = 0;
			m_last  = 0;
			m_count = 0;
			m_valid = 1'b0;
			m_delay = RESPAWN_DELAY - 1;
		end
		else if (enable)
		begin
			g = '0;
			c = 1'b0;
			a = 1'b0;
			// a pickup being collected is still shown for one tick
			on_tile = obs_pickup.valid && !m_collect
				&& obs_pickup.xpos == tank.xpos && obs_pickup.ypos == tank.ypos;
			if (|cheat)
			begin
				if (cheat.shield || cheat.protect)
					g[SLOT_INVINCIBLE] = 1'b1;
				else if (cheat.speed)
					g[SLOT_FASTER] = 1'b1;
				else if (cheat.freeze)
					g[SLOT_FROZEN] = 1'b1;
				else if (cheat.laser)
					g[SLOT_LASER] = 1'b1;
			end
			else if (on_tile)
			begin
				c = 1'b1;
				case (obs_pickup.kind)
					KIND_SHIELD:
					begin
						if (mode_classic)
							g[SLOT_INVINCIBLE] = 1'b1;
						else if (mode_infinity)
							a = 1'b1;
					end
					KIND_SPEED:  g[SLOT_FASTER] = 1'b1;
					KIND_FREEZE: g[SLOT_FROZEN] = 1'b1;
					KIND_LASER:  g[SLOT_LASER] = 1'b1;
					default:     g = '0;
				endcase
			end
			for (int i = 0; i < NUM_TIMED; i++)
			begin
				if (m_grant[i])
				begin
					m_rem[i] = DURATION;
					m_last   = i;
				end
				else if (m_rem[i] > 0)
				begin
					m_rem[i]--;
				end
			end
			if (m_collect && m_count < 255)
				m_count++;
			if (m_valid)
			begin
				if (m_collect)
				begin
					m_valid = 1'b0;
					m_delay = RESPAWN_DELAY - 1;
				end
			end
			else if (m_delay == 0)
				m_valid = 1'b1;
			else
				m_delay--;
			m_grant   = g;
			m_collect = c;
			m_addtime = a;
		end
	end

	always @(negedge clk_4Hz)
	begin : output_check
		reward_flags_t exp_flags;
		if (!reset)
		begin
			exp_flags.invincible = (m_rem[SLOT_INVINCIBLE] != 0);
			exp_flags.addtime    = m_addtime;
			exp_flags.faster     = (m_rem[SLOT_FASTER] != 0);
			exp_flags.frozen     = (m_rem[SLOT_FROZEN] != 0);
			exp_flags.laser      = (m_rem[SLOT_LASER] != 0);
			compare_hex("flags", 32'(flags), 32'(exp_flags));
			compare_hex("last_remaining", 32'(last_remaining), 32'(m_rem[m_last]));
			compare_hex("collected_count", 32'(collected_count), 32'(m_count));
			compare_hex("pickup.valid", 32'(pickup.valid), 32'(m_valid));
			if (pickup.valid)
			begin
				expect_true(pickup.kind >= KIND_SHIELD && pickup.kind <= KIND_LASER,
					"a shown pickup has a kind outside 1..4");
				// a shown pickup keeps its tile and kind until it is taken
				if (prev_pickup.valid)
					compare_hex("pickup", 32'(pickup), 32'(prev_pickup));
			end
		end
		prev_pickup = pickup;
		obs_pickup  = pickup;
	end

	task automatic wait_ticks(input int n);
		repeat (n) @(posedge clk_4Hz);
	endtask

	task automatic move_tank_to_pickup();
		tank.xpos <= obs_pickup.xpos;
		tank.ypos <= obs_pickup.ypos;
	endtask

	task automatic move_tank_random();
		logic [31:0] r;
		r = $urandom;
		tank.xpos <= r[4:0];
		tank.ypos <= r[9:5];
	endtask

	task automatic toggle_mode();
		mode_classic  <= !mode_classic;
		mode_infinity <= mode_classic;
	endtask

	task automatic wait_for_pickup();
		int waited;
		waited = 0;
		while (!obs_pickup.valid && waited < PICKUP_WAIT)
		begin
			@(posedge clk_4Hz);
			waited++;
		end
		expect_true(obs_pickup.valid, "no pickup appeared within the respawn delay");
	endtask

	task automatic collect_rounds(input int rounds, inout int taken);
		int waited;
		for (int i = 0; i < rounds; i++)
		begin
			wait_for_pickup();
			move_tank_to_pickup();
			waited = 0;
			while (obs_pickup.valid && waited < 8)
			begin
				@(posedge clk_4Hz);
				waited++;
			end
			expect_true(!obs_pickup.valid, "pickup was not taken with the tank on it");
			taken++;
		end
	endtask

	// one random choice per tick where a cheat lasts a single tick
	task automatic random_tick();
		logic [31:0] r;
		logic [31:0] pattern;
		r       = $urandom % 100;
		pattern = $urandom;
		cheat  <= '0;
		enable <= (pattern[31:28] != 4'd0);
		if (r >= 40 && r < 65)
			move_tank_to_pickup();
		else if (r >= 65 && r < 88)
			move_tank_random();
		else if (r >= 88 && r < 94)
			cheat <= cheat_t'(pattern[4:0]);
		else if (r >= 94)
			toggle_mode();
	endtask

	task automatic begin_test();
		test_start_errors = errors;
	endtask

	task automatic end_test(input int num, input string name);
		int failed;
		failed = errors - test_start_errors;
		tests_run++;
		if (failed == 0)
			$display("test %0d %s: ok", num, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: %0d errors", num, name, failed);
		end
	endtask

	initial
	begin
		#(PLAN_TICKS * 40 + PLAN_TICKS * 20);
		$display("watchdog expired before the tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin : stimulus
		int low_ticks;
		int taken;
		int count_before;
		reward_flags_t snap_flags;
		logic [CNT_W-1:0] snap_rem;
		logic [7:0] snap_count;
		pickup_t snap_pickup;
		void'($urandom(78614));
		errors        = 0;
		tests_run     = 0;
		tests_failed  = 0;
		reset         = 1'b1;
		enable        = 1'b1;
		mode_classic  = 1'b1;
		mode_infinity = 1'b0;
		tank          = '0;
		cheat         = '0;
		obs_pickup    = '0;
		prev_pickup   = '0;

		begin_test();
		wait_ticks(16);
		reset <= 1'b0;
		@(negedge clk_4Hz);
		compare_hex("flags after reset", 32'(flags), 32'h0);
		compare_hex("collected_count after reset", 32'(collected_count), 32'h0);
		low_ticks = 0;
		while (!pickup.valid && low_ticks <= PICKUP_WAIT)
		begin
			low_ticks++;
			@(negedge clk_4Hz);
		end
		compare_hex("ticks without pickup after reset", 32'(low_ticks), 32'(RESPAWN_DELAY));
		@(posedge clk_4Hz);
		end_test(1, "reset and first spawn");

		begin_test();
		count_before = int'(collected_count);
		taken = 0;
		collect_rounds(COLLECT_ROUNDS, taken);
		toggle_mode();
		collect_rounds(COLLECT_ROUNDS, taken);
		move_tank_random();
		wait_ticks(DURATION + 4);
		@(negedge clk_4Hz);
		compare_hex("collected_count", 32'(collected_count), 32'(count_before + taken));
		@(posedge clk_4Hz);
		toggle_mode();
		end_test(2, "collection in both modes");

		begin_test();
		wait_for_pickup();
		move_tank_to_pickup();
		cheat <= '{shield: 1'b0, speed: 1'b1, freeze: 1'b1, laser: 1'b1, protect: 1'b0};
		count_before = int'(collected_count);
		wait_ticks(4);
		@(negedge clk_4Hz);
		expect_true(flags.faster && !flags.frozen && !flags.laser,
			"speed did not win over freeze and laser");
		@(posedge clk_4Hz);
		cheat <= '{shield: 1'b1, speed: 1'b1, freeze: 1'b1, laser: 1'b1, protect: 1'b1};
		wait_ticks(3);
		@(negedge clk_4Hz);
		expect_true(flags.invincible, "protect did not grant invincibility");
		expect_true(pickup.valid, "pickup was consumed while a cheat was held");
		compare_hex("collected_count under cheat", 32'(collected_count), 32'(count_before));
		@(posedge clk_4Hz);
		cheat <= '0;
		move_tank_random();
		wait_ticks(DURATION + 2);
		end_test(3, "cheat priority");

		begin_test();
		count_before = int'(collected_count);
		cheat <= '{shield: 1'b0, speed: 1'b1, freeze: 1'b0, laser: 1'b0, protect: 1'b0};
		wait_ticks(1);
		cheat <= '0;
		wait_ticks(4);
		cheat <= '{shield: 1'b0, speed: 1'b0, freeze: 1'b1, laser: 1'b0, protect: 1'b0};
		wait_ticks(1);
		cheat <= '0;
		wait_ticks(10);
		cheat <= '{shield: 1'b0, speed: 1'b1, freeze: 1'b0, laser: 1'b0, protect: 1'b0};
		wait_ticks(1);
		cheat <= '0;
		wait_ticks(DURATION - 7);
		@(negedge clk_4Hz);
		// speed was reloaded 22 ticks before this check and has 8 ticks left
		expect_true(flags.faster, "regranted speed expired with the first grant");
		compare_hex("last_remaining after regrant", 32'(last_remaining), 32'd8);
		if (int'(collected_count) == count_before)
			expect_true(!flags.frozen, "freeze outlived its duration");
		@(posedge clk_4Hz);
		wait_ticks(DURATION);
		end_test(4, "independent timers and restart");

		begin_test();
		wait_for_pickup();
		cheat <= '{shield: 1'b0, speed: 1'b0, freeze: 1'b0, laser: 1'b1, protect: 1'b0};
		wait_ticks(1);
		cheat <= '0;
		wait_ticks(3);
		enable <= 1'b0;
		move_tank_to_pickup();
		@(negedge clk_4Hz);
		snap_flags  = flags;
		snap_rem    = last_remaining;
		snap_count  = collected_count;
		snap_pickup = pickup;
		repeat (20)
		begin
			@(negedge clk_4Hz);
			compare_hex("flags while disabled", 32'(flags), 32'(snap_flags));
			compare_hex("last_remaining while disabled", 32'(last_remaining), 32'(snap_rem));
			compare_hex("collected_count while disabled", 32'(collected_count),
				32'(snap_count));
			compare_hex("pickup while disabled", 32'(pickup), 32'(snap_pickup));
		end
		@(posedge clk_4Hz);
		enable <= 1'b1;
		end_test(5, "enable gating");

		begin_test();
		repeat (RANDOM_TICKS)
		begin
			random_tick();
			@(posedge clk_4Hz);
		end
		end_test(6, "random run");

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* tb.f */
hdl/reward_pkg.sv
hdl/pickup_spawner.sv
hdl/reward_dispatch.sv
hdl/reward_timer.sv
hdl/reward_status.sv
hdl/reward_top.sv
tb/tb_reward.sv

/* run_sim.sh */
#!/bin/sh
# Compiles the power-up subsystem testbench with Verilator, runs it and
# decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
EXE=sim_tb_reward

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module tb_reward -Mdir "$BUILD_DIR" -o "$EXE"
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
